//--- source/tk1_pkg.sv
`default_nettype none

package tk1_pkg;

  // ------------------------------
  // Vector types
  // ------------------------------
  typedef logic [31:0] bus_word_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] cpu_addr_t;

  // Red in bit 2, green in bit 1, blue in bit 0
  typedef logic [2:0]  led_t;

  typedef logic [2:0]  cdi_index_t;

  typedef enum logic {
    MODE_FIRMWARE = 1'b0,
    MODE_APP      = 1'b1
  } mode_state_t;

  // Kept short so the trap blink shows up in simulation
  localparam int BLINK_CTR_WIDTH = 6;
  typedef logic [BLINK_CTR_WIDTH-1:0] blink_ctr_t;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam reg_addr_t ADDR_NAME0         = 8'h00;
  localparam reg_addr_t ADDR_NAME1         = 8'h01;
  localparam reg_addr_t ADDR_VERSION       = 8'h02;
  localparam reg_addr_t ADDR_SYSTEM_MODE   = 8'h08;
  localparam reg_addr_t ADDR_LED           = 8'h09;
  localparam reg_addr_t ADDR_APP_START     = 8'h0c;
  localparam reg_addr_t ADDR_APP_SIZE      = 8'h0d;
  localparam reg_addr_t ADDR_SYSCALL       = 8'h12;
  localparam reg_addr_t ADDR_CDI_FIRST     = 8'h20;
  localparam reg_addr_t ADDR_CDI_LAST      = 8'h27;
  localparam reg_addr_t ADDR_CPU_MON_CTRL  = 8'h60;
  localparam reg_addr_t ADDR_CPU_MON_FIRST = 8'h61;
  localparam reg_addr_t ADDR_CPU_MON_LAST  = 8'h62;

  // ------------------------------
  // Constants
  // ------------------------------
  localparam bus_word_t TK1_NAME0      = 32'h746b3120;  // "tk1 "
  localparam bus_word_t TK1_NAME1      = 32'h6d6b6466;  // "mkdf"
  localparam bus_word_t TK1_VERSION    = 32'h00000005;
  localparam bus_word_t APP_SIZE_RESET = 32'h00000000;

  // No physical memory here, any access traps in the monitor
  localparam cpu_addr_t ILLEGAL_ADDR   = 32'h4f000000;

  localparam cpu_addr_t FW_RAM_FIRST   = 32'hd0000000;
  localparam cpu_addr_t FW_RAM_LAST    = 32'hd00007ff;
  localparam cpu_addr_t FW_ROM_LAST    = 32'h00001fff;

  localparam led_t LED_RESET       = 3'b110;
  localparam led_t TRAP_LED_TOGGLE = 3'b100;

endpackage

`default_nettype wire

//--- source/monitor_cfg_if.sv
`default_nettype none

// Monitor window and syscall address, from the register file to the checkers
interface monitor_cfg_if;

  logic               mon_en;
  tk1_pkg::cpu_addr_t mon_first;
  tk1_pkg::cpu_addr_t mon_last;
  tk1_pkg::cpu_addr_t syscall_addr;

  modport driver (
    output mon_en,
    output mon_first,
    output mon_last,
    output syscall_addr
  );

  modport monitor (
    input mon_en,
    input mon_first,
    input mon_last
  );

  modport mode (
    input syscall_addr
  );

endinterface

`default_nettype wire

//--- source/tk1_regs.sv
`default_nettype none

module tk1_regs (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                cs,
  input  logic                we,
  input  tk1_pkg::reg_addr_t  address,
  input  tk1_pkg::bus_word_t  write_data,
  output tk1_pkg::bus_word_t  read_data,
  output logic                ready,
  input  logic                system_mode,
  output tk1_pkg::led_t       led_reg,
  monitor_cfg_if.driver       cfg
);

  tk1_pkg::bus_word_t  app_start_reg;
  tk1_pkg::bus_word_t  app_size_reg;
  tk1_pkg::cpu_addr_t  syscall_reg;
  tk1_pkg::bus_word_t  cdi_mem [8];

  logic                mon_en_reg;
  tk1_pkg::cpu_addr_t  mon_first_reg;
  tk1_pkg::cpu_addr_t  mon_last_reg;

  logic                wr_access;
  logic                rd_access;
  logic                fw_wr;
  logic                cdi_hit;
  tk1_pkg::cdi_index_t cdi_idx;

  // ------------------------------
  // Decode
  // ------------------------------
  // No wait states, every access completes in its own cycle
  assign ready     = cs;
  assign wr_access = cs && we;
  assign rd_access = cs && !we;

  // Protected registers only change in firmware mode
  assign fw_wr     = wr_access && !system_mode;

  assign cdi_hit   = (address >= tk1_pkg::ADDR_CDI_FIRST) &&
                     (address <= tk1_pkg::ADDR_CDI_LAST);
  assign cdi_idx   = address[2:0];

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_reg       <= tk1_pkg::LED_RESET;
      app_start_reg <= '0;
      app_size_reg  <= tk1_pkg::APP_SIZE_RESET;
      syscall_reg   <= tk1_pkg::ILLEGAL_ADDR;
      mon_en_reg    <= 1'b0;
      mon_first_reg <= '0;
      mon_last_reg  <= '0;
    end else begin
      // LED is open to the application as well
      if (wr_access && (address == tk1_pkg::ADDR_LED)) begin
        led_reg <= write_data[2:0];
      end

      if (fw_wr && (address == tk1_pkg::ADDR_APP_START)) begin
        app_start_reg <= write_data;
      end

      if (fw_wr && (address == tk1_pkg::ADDR_APP_SIZE)) begin
        app_size_reg <= write_data;
      end

      if (fw_wr && (address == tk1_pkg::ADDR_SYSCALL)) begin
        syscall_reg <= write_data;
      end

      // Enable is sticky, any write turns it on
      if (wr_access && (address == tk1_pkg::ADDR_CPU_MON_CTRL)) begin
        mon_en_reg <= 1'b1;
      end

      // Window is frozen once the monitor runs
      if (wr_access && !mon_en_reg) begin
        if (address == tk1_pkg::ADDR_CPU_MON_FIRST) begin
          mon_first_reg <= write_data;
        end
        if (address == tk1_pkg::ADDR_CPU_MON_LAST) begin
          mon_last_reg <= write_data;
        end
      end
    end
  end

  // CDI words
  always_ff @(posedge clk) begin
    if (fw_wr && cdi_hit) begin
      cdi_mem[cdi_idx] <= write_data;
    end
  end

  assign cfg.mon_en       = mon_en_reg;
  assign cfg.mon_first    = mon_first_reg;
  assign cfg.mon_last     = mon_last_reg;
  assign cfg.syscall_addr = syscall_reg;

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    read_data = '0;
    if (rd_access) begin
      case (address)
        tk1_pkg::ADDR_NAME0:         read_data = tk1_pkg::TK1_NAME0;
        tk1_pkg::ADDR_NAME1:         read_data = tk1_pkg::TK1_NAME1;
        tk1_pkg::ADDR_VERSION:       read_data = tk1_pkg::TK1_VERSION;
        tk1_pkg::ADDR_SYSTEM_MODE:   read_data = {$bits(tk1_pkg::bus_word_t){system_mode}};
        tk1_pkg::ADDR_LED:           read_data = tk1_pkg::bus_word_t'(led_reg);
        tk1_pkg::ADDR_APP_START:     read_data = app_start_reg;
        tk1_pkg::ADDR_APP_SIZE:      read_data = app_size_reg;
        tk1_pkg::ADDR_SYSCALL:       read_data = syscall_reg;
        tk1_pkg::ADDR_CPU_MON_CTRL:  read_data = tk1_pkg::bus_word_t'(mon_en_reg);
        tk1_pkg::ADDR_CPU_MON_FIRST: read_data = mon_first_reg;
        tk1_pkg::ADDR_CPU_MON_LAST:  read_data = mon_last_reg;
        default: begin
          if (cdi_hit) begin
            read_data = cdi_mem[cdi_idx];
          end
        end
      endcase
    end
  end

  // Application code cannot move its own entry points
  app_regs_locked : assert property (
    @(posedge clk) disable iff (!reset_n)
    system_mode |=> $stable(app_start_reg) && $stable(app_size_reg) && $stable(syscall_reg)
  );

endmodule

`default_nettype wire

//--- source/privilege_fsm.sv
`default_nettype none

module privilege_fsm (
  input  logic               clk,
  input  logic               reset_n,
  input  tk1_pkg::cpu_addr_t cpu_addr,
  input  logic               cpu_instr,
  input  logic               cpu_valid,
  monitor_cfg_if.mode        cfg,
  output logic               system_mode
);

  tk1_pkg::mode_state_t state;
  tk1_pkg::mode_state_t state_next;

  logic fetch;
  logic above_rom;
  logic syscall_hit;

  assign fetch       = cpu_valid && cpu_instr;
  assign above_rom   = cpu_addr > tk1_pkg::FW_ROM_LAST;
  assign syscall_hit = cpu_addr == cfg.syscall_addr;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      tk1_pkg::MODE_FIRMWARE: begin
        // Leaving the ROM drops privilege
        if (fetch && above_rom) begin
          state_next = tk1_pkg::MODE_APP;
        end
      end
      tk1_pkg::MODE_APP: begin
        // Only a syscall entry inside the ROM raises it again
        if (fetch && syscall_hit && !above_rom) begin
          state_next = tk1_pkg::MODE_FIRMWARE;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= tk1_pkg::MODE_FIRMWARE;
    end else begin
      state <= state_next;
    end
  end

  assign system_mode = (state == tk1_pkg::MODE_APP);

  // Code outside the ROM never runs privileged
  app_after_rom_exit : assert property (
    @(posedge clk) disable iff (!reset_n)
    fetch && above_rom |=> state == tk1_pkg::MODE_APP
  );

endmodule

`default_nettype wire

//--- source/exec_monitor.sv
`default_nettype none

module exec_monitor (
  input  logic               clk,
  input  logic               reset_n,
  input  tk1_pkg::cpu_addr_t cpu_addr,
  input  logic               cpu_instr,
  input  logic               cpu_valid,
  monitor_cfg_if.monitor     cfg,
  output logic               force_trap
);

  logic fetch;
  logic ram_violation;
  logic fw_ram_fetch;
  logic window_fetch;
  logic trap_set;

  assign fetch = cpu_valid && cpu_instr;

  // ------------------------------
  // Violation checks
  // ------------------------------
  // RAM region beyond the physical size
  assign ram_violation = cpu_valid && (cpu_addr[31:30] == 2'b01) && (|cpu_addr[29:17]);

  // Firmware RAM is data only
  assign fw_ram_fetch  = fetch &&
                         (cpu_addr >= tk1_pkg::FW_RAM_FIRST) &&
                         (cpu_addr <= tk1_pkg::FW_RAM_LAST);

  // Window set up by firmware, checked only once enabled
  assign window_fetch  = fetch && cfg.mon_en &&
                         (cpu_addr >= cfg.mon_first) &&
                         (cpu_addr <= cfg.mon_last);

  assign trap_set = ram_violation || fw_ram_fetch || window_fetch;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap <= 1'b0;
    end else if (trap_set) begin
      force_trap <= 1'b1;
    end
  end

  trap_is_sticky : assert property (
    @(posedge clk) disable iff (!reset_n) force_trap |=> force_trap
  );

endmodule

`default_nettype wire

//--- source/trap_led_blinker.sv
`default_nettype none

module trap_led_blinker (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          cpu_trap,
  input  tk1_pkg::led_t led_reg,
  output logic          led_r,
  output logic          led_g,
  output logic          led_b
);

  tk1_pkg::blink_ctr_t blink_ctr;
  tk1_pkg::led_t       trap_led;
  tk1_pkg::led_t       led_mux;

  // ------------------------------
  // Blink timer
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      blink_ctr <= '0;
      trap_led  <= '0;
    end else begin
      blink_ctr <= blink_ctr + tk1_pkg::blink_ctr_t'(1);
      // Toggle red once per wrap
      if (blink_ctr == '0) begin
        trap_led <= trap_led ^ tk1_pkg::TRAP_LED_TOGGLE;
      end
    end
  end

  // Trapped CPU takes over the LEDs
  assign led_mux = cpu_trap ? trap_led : led_reg;

  assign led_r = led_mux[2];
  assign led_g = led_mux[1];
  assign led_b = led_mux[0];

endmodule

`default_nettype wire

//--- source/tk1_core.sv
`default_nettype none

module tk1_core (
  input  logic               clk,
  input  logic               reset_n,

  input  logic               cpu_trap,
  input  tk1_pkg::cpu_addr_t cpu_addr,
  input  logic               cpu_instr,
  input  logic               cpu_valid,
  output logic               system_mode,
  output logic               force_trap,

  output logic               led_r,
  output logic               led_g,
  output logic               led_b,

  input  logic               cs,
  input  logic               we,
  input  tk1_pkg::reg_addr_t address,
  input  tk1_pkg::bus_word_t write_data,
  output tk1_pkg::bus_word_t read_data,
  output logic               ready
);

  tk1_pkg::led_t led_reg;

  monitor_cfg_if cfg_if ();

  tk1_regs u_tk1_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .read_data   (read_data),
    .ready       (ready),
    .system_mode (system_mode),
    .led_reg     (led_reg),
    .cfg         (cfg_if.driver)
  );

  privilege_fsm u_privilege_fsm (
    .clk         (clk),
    .reset_n     (reset_n),
    .cpu_addr    (cpu_addr),
    .cpu_instr   (cpu_instr),
    .cpu_valid   (cpu_valid),
    .cfg         (cfg_if.mode),
    .system_mode (system_mode)
  );

  exec_monitor u_exec_monitor (
    .clk        (clk),
    .reset_n    (reset_n),
    .cpu_addr   (cpu_addr),
    .cpu_instr  (cpu_instr),
    .cpu_valid  (cpu_valid),
    .cfg        (cfg_if.monitor),
    .force_trap (force_trap)
  );

  trap_led_blinker u_trap_led_blinker (
    .clk      (clk),
    .reset_n  (reset_n),
    .cpu_trap (cpu_trap),
    .led_reg  (led_reg),
    .led_r    (led_r),
    .led_g    (led_g),
    .led_b    (led_b)
  );

endmodule

`default_nettype wire

//--- tests/tk1_core_tb.sv
`default_nettype none

module tk1_core_tb;

  localparam int BLINK_PERIOD = 1 << tk1_pkg::BLINK_CTR_WIDTH;
  localparam string TRACE_FILE = "tests/tk1_core_trace.txt";

  logic               clk;
  logic               reset_n;
  logic               cpu_trap;
  tk1_pkg::cpu_addr_t cpu_addr;
  logic               cpu_instr;
  logic               cpu_valid;
  logic               cs;
  logic               we;
  tk1_pkg::reg_addr_t address;
  tk1_pkg::bus_word_t write_data;
  logic               system_mode;
  logic               force_trap;
  logic               led_r;
  logic               led_g;
  logic               led_b;
  tk1_pkg::bus_word_t read_data;
  logic               ready;

  // Trace columns, one entry per operation
  string       name_q[$];
  string       op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic        limit_set = 1'b0;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  tk1_core u_tk1_core (
    .clk         (clk),
    .reset_n     (reset_n),
    .cpu_trap    (cpu_trap),
    .cpu_addr    (cpu_addr),
    .cpu_instr   (cpu_instr),
    .cpu_valid   (cpu_valid),
    .system_mode (system_mode),
    .force_trap  (force_trap),
    .led_r       (led_r),
    .led_g       (led_g),
    .led_b       (led_b),
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .read_data   (read_data),
    .ready       (ready)
  );

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string test, input tk1_pkg::bus_word_t exp,
                            input tk1_pkg::bus_word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_mode(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected mode %b, actual %b", test, exp, act));
    end
  endtask

  task automatic check_trap(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected trap %b, actual %b", test, exp, act));
    end
  endtask

  task automatic check_ready(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected ready %b, actual %b", test, exp, act));
    end
  endtask

  task automatic check_led(input string test, input tk1_pkg::led_t exp,
                           input tk1_pkg::led_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("mismatch %s: expected led %b, actual %b", test, exp, act));
    end
  endtask

  // ------------------------------
  // Trace and stimulus
  // ------------------------------
  task automatic load_trace;
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      stop_on_error({"cannot open the trace file ", TRACE_FILE});
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip comments and blank lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %h %h %h", name, op, a, d, e);
        if (n != 5) begin
          stop_on_error({"the trace file has a malformed line: ", line});
        end
        name_q.push_back(name);
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        exp_q.push_back(e);
      end
    end
    $fclose(fd);
    if (name_q.size() == 0) begin
      stop_on_error("the trace file holds no operations");
    end
  endtask

  task automatic apply_reset;
    @(posedge clk);
    reset_n   <= 1'b0;
    cs        <= 1'b0;
    we        <= 1'b0;
    cpu_valid <= 1'b0;
    cpu_instr <= 1'b0;
    cpu_trap  <= 1'b0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b1;
    address    <= addr[7:0];
    write_data <= data;
    @(posedge clk);
    cs <= 1'b0;
    we <= 1'b0;
  endtask

  // Read data is valid in the cycle of the access
  task automatic bus_read(input string test, input logic [31:0] addr,
                          input logic [31:0] exp);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b0;
    address    <= addr[7:0];
    write_data <= '0;
    @(negedge clk);
    check_ready(test, 1'b1, ready);
    check_word(test, exp, read_data);
    @(posedge clk);
    cs <= 1'b0;
  endtask

  // Expected column is {system_mode, force_trap} after the access
  task automatic cpu_access(input string test, input logic [31:0] addr,
                            input logic instr, input logic [31:0] exp);
    @(posedge clk);
    cpu_valid <= 1'b1;
    cpu_instr <= instr;
    cpu_addr  <= addr;
    @(posedge clk);
    cpu_valid <= 1'b0;
    cpu_instr <= 1'b0;
    @(negedge clk);
    check_mode(test, exp[1], system_mode);
    check_trap(test, exp[0], force_trap);
  endtask

  task automatic blink_check(input string test, input logic trap, input logic [31:0] exp);
    logic first_red;
    int   waited;
    @(posedge clk);
    cpu_trap <= trap;
    @(negedge clk);
    if (trap) begin
      // Trap pattern only ever lights red
      check_led(test, 3'b000, {1'b0, led_g, led_b});
      first_red = led_r;
      waited = 0;
      while (led_r === first_red && waited <= BLINK_PERIOD) begin
        @(negedge clk);
        waited++;
      end
      if (led_r === first_red) begin
        stop_on_error({test, ": the red LED did not toggle within one blink period"});
      end
      check_led(test, 3'b000, {1'b0, led_g, led_b});
    end else begin
      check_led(test, exp[2:0], {led_r, led_g, led_b});
    end
  endtask

  task automatic idle_gap(input string test);
    int gap;
    gap = $urandom % 4;
    repeat (gap) begin
      @(negedge clk);
      check_ready(test, 1'b0, ready);
    end
  endtask

  // ------------------------------
  // Timeout
  // ------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (limit_set && cycle_count > cycle_limit) begin
      stop_on_error($sformatf("timeout: the trace did not finish in %0d cycles", cycle_limit));
    end
  end

  initial begin
    void'($urandom(32'h3b84));
    reset_n    = 1'b0;
    cpu_trap   = 1'b0;
    cpu_addr   = '0;
    cpu_instr  = 1'b0;
    cpu_valid  = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;

    load_trace();
    cycle_limit = name_q.size() * 8 + 4 * BLINK_PERIOD;
    limit_set   = 1'b1;
    apply_reset();

    foreach (name_q[i]) begin
      idle_gap(name_q[i]);
      case (op_q[i])
        "write":  bus_write(addr_q[i], data_q[i]);
        "read":   bus_read(name_q[i], addr_q[i], exp_q[i]);
        "fetch":  cpu_access(name_q[i], addr_q[i], 1'b1, exp_q[i]);
        "access": cpu_access(name_q[i], addr_q[i], 1'b0, exp_q[i]);
        "blink":  blink_check(name_q[i], data_q[i][0], exp_q[i]);
        "reset":  apply_reset();
        default:  stop_on_error({name_q[i], ": unknown operation ", op_q[i]});
      endcase
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: tk1_core

sources:
  - source/tk1_pkg.sv
  - source/monitor_cfg_if.sv
  - source/tk1_regs.sv
  - source/privilege_fsm.sv
  - source/exec_monitor.sv
  - source/trap_led_blinker.sv
  - source/tk1_core.sv
  - target: test
    files:
      - tests/tk1_core_tb.sv

//--- compile.f
source/tk1_pkg.sv
source/monitor_cfg_if.sv
source/tk1_regs.sv
source/privilege_fsm.sv
source/exec_monitor.sv
source/trap_led_blinker.sv
source/tk1_core.sv
tests/tk1_core_tb.sv

//--- tests/tk1_core_trace.txt
# name op address data expected (hex); fetch and access expect {system_mode, force_trap}
# blink drives cpu_trap from data and expects the LED pattern while cpu_trap is low
id_name0 read 00 0 746b3120
id_name1 read 01 0 6d6b6466
id_version read 02 0 00000005
led_at_reset read 09 0 6
mode_at_reset read 08 0 0
rom_data_access access 00000100 0 0
unmapped_read read 03 0 0
fw_app_start write 0c 40000000 0
fw_app_start_rb read 0c 0 40000000
fw_app_size write 0d 00001000 0
fw_app_size_rb read 0d 0 00001000
fw_syscall write 12 00000040 0
fw_syscall_rb read 12 0 00000040
fw_cdi0 write 20 a5a5a5a5 0
fw_cdi7 write 27 12345678 0
fw_cdi0_rb read 20 0 a5a5a5a5
fw_cdi7_rb read 27 0 12345678
enter_app fetch 40000000 0 2
app_mode_rd read 08 0 ffffffff
app_start_lock write 0c deadbeef 0
app_start_kept read 0c 0 40000000
app_size_lock write 0d 00002000 0
app_size_kept read 0d 0 00001000
app_syscall_lock write 12 00000080 0
app_syscall_kept read 12 0 00000040
app_cdi_lock write 27 0 0
app_cdi_kept read 27 0 12345678
app_led write 09 1 0
app_led_rb read 09 0 1
rom_not_syscall fetch 00000080 0 2
syscall_entry fetch 00000040 0 0
fw_mode_rd read 08 0 0
fw_led write 09 3 0
mon_first write 61 40000100 0
mon_last write 62 400001ff 0
mon_first_rb read 61 0 40000100
mon_last_rb read 62 0 400001ff
mon_enable write 60 1 0
mon_enable_rb read 60 0 1
mon_first_lock write 61 0 0
mon_first_kept read 61 0 40000100
mon_last_lock write 62 ffffffff 0
mon_last_kept read 62 0 400001ff
mon_outside fetch 40000000 0 2
mon_inside fetch 40000180 0 3
trap_sticky access 00000100 0 3
blink_trap blink 0 1 0
blink_release blink 0 0 3
fresh_reset_a reset 0 0 0
ram_in_range access 4001fffc 0 0
ram_illegal access 40020000 0 1
fresh_reset_b reset 0 0 0
fwram_data access d0000010 0 0
fwram_fetch fetch d0000010 0 3
led_after_reset blink 0 0 6
